// File: verilog/uart_pkg.sv
// =====================================================================
// uart package
// register map, bit positions, reset values, shared types and the
// parity rule used by both the transmitter and the receiver
// =====================================================================
`default_nettype none

package uart_pkg;

	localparam int ADDR_W        = 3;     // register address bits
	localparam int DIV_W         = 16;    // divisor latch width
	localparam int FIFO_DEPTH    = 16;    // entries per fifo
	localparam int CNT_W         = 5;     // fifo count, 0..16
	localparam int TICKS_PER_BIT = 16;    // baud ticks per serial bit

	localparam logic [ADDR_W-1:0] REG_RB = 3'd0;   // rbr on read, thr on write, dll
	localparam logic [ADDR_W-1:0] REG_IE = 3'd1;   // ier or dlm
	localparam logic [ADDR_W-1:0] REG_II = 3'd2;   // iir on read, fcr on write
	localparam logic [ADDR_W-1:0] REG_LC = 3'd3;
	localparam logic [ADDR_W-1:0] REG_LS = 3'd5;

	localparam logic [7:0] LCR_RST = 8'h03;  // 8 data bits, no parity
	localparam logic [7:0] IIR_RST = 8'hC0;  // fifos on, nothing pending
	localparam logic [7:0] LSR_RST = 8'h60;  // thr and tx empty

	localparam int LC_DL   = 7;   // divisor latch access

	localparam int IE_RDA  = 0;
	localparam int IE_THRE = 1;
	localparam int IE_RLS  = 2;

	localparam int LS_DR   = 0;   // data ready
	localparam int LS_OE   = 1;   // overrun
	localparam int LS_PE   = 2;   // parity error
	localparam int LS_FE   = 3;   // framing error
	localparam int LS_TFE  = 5;   // tx fifo empty
	localparam int LS_TE   = 6;   // tx fifo and shifter empty

	// interrupt ids, iir bits 3:1
	localparam logic [2:0] II_RLS  = 3'b011;
	localparam logic [2:0] II_RDA  = 3'b010;
	localparam logic [2:0] II_THRE = 3'b001;

	typedef struct packed {
		logic       dlab;
		logic       break_ctl;   // no effect here
		logic       stick_par;
		logic       even_par;
		logic       par_en;
		logic       stop_bits;   // always one stop bit sent
		logic [1:0] wls;         // 0..3 -> 5..8 data bits
	} lcr_t;

	typedef struct packed {
		logic [7:0] data;
		logic       parity_err;
		logic       frame_err;
	} rx_char_t;

	// keeps only the bits of the selected word length
	function automatic logic [7:0] word_mask(input logic [1:0] wls);
		word_mask = 8'hFF >> (2'd3 - wls);
	endfunction

	// parity bit for a word under the lcr rule
	function automatic logic parity_bit(input lcr_t lcr, input logic [7:0] data);
		logic x;
		x = ^(data & word_mask(lcr.wls));
		case ({lcr.even_par, lcr.stick_par})
			2'b00:   parity_bit = ~x;    // odd
			2'b10:   parity_bit = x;     // even
			2'b01:   parity_bit = 1'b1;  // stuck at 1
			default: parity_bit = 1'b0;  // stuck at 0
		endcase
	endfunction

endpackage

`default_nettype wire

// File: verilog/uart_baud_gen.sv
// =====================================================================
// uart baud generator
// divisor down-counter, one-clock tick every divisor+1 clocks
// =====================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_baud_gen (
	input  wire logic                      clk,
	input  wire logic                      wb_rst_i,
	input  wire logic [uart_pkg::DIV_W-1:0] div_i,
	output logic                           tick_o
);
	import uart_pkg::*;

	logic [DIV_W-1:0] cnt_q;

	always_ff @(posedge clk or posedge wb_rst_i)
		if (wb_rst_i)
			cnt_q <= '1;                   // no tick until a divisor is set
		else if (div_i == '0)
			cnt_q <= '1;                   // stopped
		else if (cnt_q == '0 || cnt_q > div_i)
			cnt_q <= div_i;                // reload, also after a smaller divisor
		else
			cnt_q <= cnt_q - 1'b1;

	assign tick_o = (cnt_q == '0);

endmodule

`default_nettype wire

// File: verilog/uart_fifo.sv
// =====================================================================
// uart fifo
// 16-deep circular buffer with fill count and sticky overrun flag
// =====================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_fifo #(
	parameter int WIDTH = 8
) (
	input  wire logic                       clk,
	input  wire logic                       wb_rst_i,
	input  wire logic                       push_i,
	input  wire logic                       pop_i,
	input  wire logic                       clr_overrun_i,
	input  wire logic [WIDTH-1:0]           data_i,
	output logic      [WIDTH-1:0]           data_o,
	output logic      [uart_pkg::CNT_W-1:0] count_o,
	output logic                            overrun_o
);
	import uart_pkg::*;

	localparam int PTR_W = $clog2(FIFO_DEPTH);

	logic [WIDTH-1:0] mem [FIFO_DEPTH];
	logic [PTR_W-1:0] rd_ptr;
	logic [PTR_W-1:0] wr_ptr;
	logic             rd_ok;
	logic             wr_ok;

	assign rd_ok = pop_i && (count_o != '0);                    // pop on empty ignored
	assign wr_ok = push_i && ((count_o != FIFO_DEPTH) || rd_ok);  // full drops the push

	always_ff @(posedge clk)
		if (wr_ok)
			mem[wr_ptr] <= data_i;

	always_ff @(posedge clk or posedge wb_rst_i)
		if (wb_rst_i)
		begin
			rd_ptr    <= '0;
			wr_ptr    <= '0;
			count_o   <= '0;
			overrun_o <= 1'b0;
		end
		else
		begin
			if (rd_ok)
				rd_ptr <= rd_ptr + 1'b1;     // wraps at depth
			if (wr_ok)
				wr_ptr <= wr_ptr + 1'b1;
			if (wr_ok && !rd_ok)
				count_o <= count_o + 1'b1;
			else if (rd_ok && !wr_ok)
				count_o <= count_o - 1'b1;
			if (push_i && !wr_ok)
				overrun_o <= 1'b1;           // set wins over clear
			else if (clr_overrun_i)
				overrun_o <= 1'b0;
		end

	assign data_o = mem[rd_ptr];          // head entry

endmodule

`default_nettype wire

// File: verilog/uart_tx.sv
// =====================================================================
// uart transmitter
// pops a byte from the tx fifo and sends start, data lsb first,
// optional parity and one stop bit, 16 ticks per bit
// =====================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
	input  wire logic            clk,
	input  wire logic            wb_rst_i,
	input  wire logic            tick_i,
	input  wire uart_pkg::lcr_t  lcr_i,
	input  wire logic [7:0]      fifo_data_i,
	input  wire logic            fifo_empty_i,
	output logic                 pop_o,
	output logic                 stx_o,
	output logic                 busy_o
);
	import uart_pkg::*;

	localparam int TCNT_W = $clog2(TICKS_PER_BIT);

	typedef enum logic [2:0] {
		S_IDLE,
		S_POP,
		S_START,
		S_DATA,
		S_PARITY,
		S_STOP
	} tx_state_t;

	tx_state_t         state;
	logic [TCNT_W-1:0] tick_cnt;
	logic [2:0]        bit_cnt;     // data bits left minus one
	logic [7:0]        shreg;
	logic              par_q;
	logic              bit_end;     // last tick of the current bit

	assign bit_end = tick_i && (tick_cnt == TCNT_W'(TICKS_PER_BIT - 1));
	assign pop_o   = (state == S_IDLE) && tick_i && !fifo_empty_i;
	assign busy_o  = (state != S_IDLE);

	always_ff @(posedge clk or posedge wb_rst_i)
		if (wb_rst_i)
		begin
			state    <= S_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			shreg    <= '0;
			par_q    <= 1'b0;
			stx_o    <= 1'b1;               // line idles high
		end
		else if (tick_i)
		begin
			if (state == S_IDLE || state == S_POP || bit_end)
				tick_cnt <= '0;
			else
				tick_cnt <= tick_cnt + 1'b1;
			case (state)
				S_IDLE:
					if (!fifo_empty_i)
					begin
						shreg <= fifo_data_i;   // head, taken with the pop
						state <= S_POP;
					end
				S_POP:
				begin
					par_q   <= parity_bit(lcr_i, shreg);
					bit_cnt <= 3'd4 + 3'(lcr_i.wls);
					stx_o   <= 1'b0;            // start bit
					state   <= S_START;
				end
				S_START:
					if (bit_end)
					begin
						stx_o <= shreg[0];
						state <= S_DATA;
					end
				S_DATA:
					if (bit_end)
					begin
						shreg <= shreg >> 1;
						if (bit_cnt != '0)
						begin
							bit_cnt <= bit_cnt - 1'b1;
							stx_o   <= shreg[1];
						end
						else if (lcr_i.par_en)
						begin
							stx_o <= par_q;
							state <= S_PARITY;
						end
						else
						begin
							stx_o <= 1'b1;      // stop bit
							state <= S_STOP;
						end
					end
				S_PARITY:
					if (bit_end)
					begin
						stx_o <= 1'b1;
						state <= S_STOP;
					end
				S_STOP:
					if (bit_end)
						state <= S_IDLE;
				default:
					state <= S_IDLE;
			endcase
		end

endmodule

`default_nettype wire

// File: verilog/uart_rx.sv
// =====================================================================
// uart receiver
// finds the start edge, samples each bit at its middle tick and
// pushes the character with its parity and framing flags
// =====================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
	input  wire logic              clk,
	input  wire logic              wb_rst_i,
	input  wire logic              tick_i,
	input  wire uart_pkg::lcr_t    lcr_i,
	input  wire logic              srx_i,
	output logic                   push_o,
	output uart_pkg::rx_char_t     char_o
);
	import uart_pkg::*;

	localparam int TCNT_W = $clog2(TICKS_PER_BIT);

	typedef enum logic [2:0] {
		R_IDLE,
		R_START,
		R_DATA,
		R_PARITY,
		R_STOP
	} rx_state_t;

	rx_state_t         state;
	logic [TCNT_W-1:0] tick_cnt;
	logic [2:0]        bit_cnt;
	logic [7:0]        shreg;
	logic              par_err;
	logic              srx_m;       // metastability flop
	logic              srx_s;       // synchronized line
	logic              srx_last;    // line at the previous tick
	logic              mid;         // middle tick of a data, parity or stop bit

	assign mid = tick_i && (tick_cnt == TCNT_W'(TICKS_PER_BIT - 1));

	// stop bit sampled this tick
	assign push_o            = (state == R_STOP) && mid;
	assign char_o.data       = shreg;
	assign char_o.parity_err = par_err;
	assign char_o.frame_err  = !srx_s;          // stop bit read as 0

	always_ff @(posedge clk or posedge wb_rst_i)
		if (wb_rst_i)
		begin
			srx_m <= 1'b1;
			srx_s <= 1'b1;
		end
		else
		begin
			srx_m <= srx_i;
			srx_s <= srx_m;
		end

	always_ff @(posedge clk or posedge wb_rst_i)
		if (wb_rst_i)
		begin
			state    <= R_IDLE;
			tick_cnt <= '0;
			bit_cnt  <= '0;
			shreg    <= '0;
			par_err  <= 1'b0;
			srx_last <= 1'b1;
		end
		else if (tick_i)
		begin
			srx_last <= srx_s;
			case (state)
				R_IDLE:
					if (srx_last && !srx_s)       // falling edge
					begin
						tick_cnt <= '0;
						state    <= R_START;
					end
				R_START:
					if (tick_cnt == TCNT_W'(TICKS_PER_BIT / 2 - 1))
					begin
						tick_cnt <= '0;
						shreg    <= '0;
						par_err  <= 1'b0;
						bit_cnt  <= 3'd4 + 3'(lcr_i.wls);
						state    <= srx_s ? R_IDLE : R_DATA;  // glitch, not a start bit
					end
					else
						tick_cnt <= tick_cnt + 1'b1;
				R_DATA:
				begin
					tick_cnt <= tick_cnt + 1'b1;        // wraps after the middle tick
					if (mid)
					begin
						// lsb first, enters at the top of the word
						shreg <= (shreg >> 1) | (8'(srx_s) << (3'd4 + 3'(lcr_i.wls)));
						if (bit_cnt != '0)
							bit_cnt <= bit_cnt - 1'b1;
						else
							state <= lcr_i.par_en ? R_PARITY : R_STOP;
					end
				end
				R_PARITY:
				begin
					tick_cnt <= tick_cnt + 1'b1;
					if (mid)
					begin
						par_err <= (srx_s != parity_bit(lcr_i, shreg));
						state   <= R_STOP;
					end
				end
				R_STOP:
				begin
					tick_cnt <= tick_cnt + 1'b1;
					if (mid)
						state <= R_IDLE;              // char pushed on this tick
				end
				default:
					state <= R_IDLE;
			endcase
		end

endmodule

`default_nettype wire

// File: verilog/uart_regs.sv
// =====================================================================
// uart register file
// bus writes, registered read mux, divisor latch, line status and
// interrupt identification with rls > rda > thre priority
// =====================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_regs (
	input  wire logic                        clk,
	input  wire logic                        wb_rst_i,
	input  wire logic [uart_pkg::ADDR_W-1:0] wb_addr_i,
	input  wire logic [7:0]                  wb_dat_i,
	input  wire logic                        wb_we_i,
	input  wire logic                        wb_stb_i,
	output logic      [7:0]                  wb_dat_o,
	output uart_pkg::lcr_t                   lcr_o,
	output logic      [uart_pkg::DIV_W-1:0]  div_o,
	output logic                             tf_push_o,
	output logic                             rf_pop_o,
	output logic                             rf_clr_overrun_o,
	input  wire uart_pkg::rx_char_t          rf_head_i,
	input  wire logic [uart_pkg::CNT_W-1:0]  rf_count_i,
	input  wire logic                        rf_overrun_i,
	input  wire logic [uart_pkg::CNT_W-1:0]  tf_count_i,
	input  wire logic                        tx_busy_i,
	output logic                             int_o
);
	import uart_pkg::*;

	lcr_t             lcr_q;
	logic [2:0]       ier_q;       // rls, thre, rda enables
	logic [1:0]       tl_q;        // fcr trigger level select
	logic [DIV_W-1:0] dl_q;
	logic [7:0]       lsr_q;
	logic [7:0]       iir_q;
	logic [CNT_W-1:0] trig;
	logic             dlab;
	logic             wr;
	logic             rd;
	logic             ls_rd;
	logic             rls;
	logic             rda;
	logic             thre;

	assign dlab  = lcr_q[LC_DL];
	assign wr    = wb_stb_i && wb_we_i;
	assign rd    = wb_stb_i && !wb_we_i;
	assign ls_rd = rd && (wb_addr_i == REG_LS);

	// thr write goes straight into the tx fifo
	assign tf_push_o        = wr && (wb_addr_i == REG_RB) && !dlab;
	assign rf_pop_o         = rd && (wb_addr_i == REG_RB) && !dlab && (rf_count_i != '0);
	assign rf_clr_overrun_o = ls_rd;                      // lsr read clears overrun

	assign lcr_o = lcr_q;
	assign div_o = dl_q;
	assign int_o = iir_q[0];

	always_comb
		case (tl_q)
			2'b00:   trig = CNT_W'(1);
			2'b01:   trig = CNT_W'(4);
			2'b10:   trig = CNT_W'(8);
			default: trig = CNT_W'(14);
		endcase

	assign rls  = ier_q[IE_RLS] && (lsr_q[LS_OE] || lsr_q[LS_PE] || lsr_q[LS_FE]);
	assign rda  = ier_q[IE_RDA] && (rf_count_i >= trig);
	assign thre = ier_q[IE_THRE] && lsr_q[LS_TFE];

	always_ff @(posedge clk or posedge wb_rst_i)
		if (wb_rst_i)
		begin
			lcr_q <= lcr_t'(LCR_RST);
			ier_q <= '0;                  // all sources masked
			tl_q  <= 2'b11;
			dl_q  <= '0;                  // baud generator stopped
		end
		else if (wr)
			case (wb_addr_i)
				REG_RB:
					if (dlab)
						dl_q[7:0] <= wb_dat_i;
				REG_IE:
					if (dlab)
						dl_q[15:8] <= wb_dat_i;
					else
						ier_q <= wb_dat_i[2:0];
				REG_II:
					tl_q <= wb_dat_i[7:6];    // fcr, only trigger level kept
				REG_LC:
					lcr_q <= lcr_t'(wb_dat_i);
				default:
					;                         // lsr is read only
			endcase

	// read data held until the next read
	always_ff @(posedge clk or posedge wb_rst_i)
		if (wb_rst_i)
			wb_dat_o <= '0;
		else if (rd)
			case (wb_addr_i)
				REG_RB:  wb_dat_o <= dlab ? dl_q[7:0] : rf_head_i.data;
				REG_IE:  wb_dat_o <= dlab ? dl_q[15:8] : {5'b0, ier_q};
				REG_II:  wb_dat_o <= iir_q;
				REG_LC:  wb_dat_o <= lcr_q;
				REG_LS:  wb_dat_o <= lsr_q;
				default: wb_dat_o <= 8'h00;
			endcase

	always_ff @(posedge clk or posedge wb_rst_i)
		if (wb_rst_i)
			lsr_q <= LSR_RST;
		else
		begin
			lsr_q[LS_DR] <= (rf_count_i != '0);
			lsr_q[LS_OE] <= rf_overrun_i;
			if (rf_pop_o)
			begin
				// flags of the character leaving the fifo
				lsr_q[LS_PE] <= lsr_q[LS_PE] | rf_head_i.parity_err;
				lsr_q[LS_FE] <= lsr_q[LS_FE] | rf_head_i.frame_err;
			end
			else if (ls_rd)
			begin
				lsr_q[LS_PE] <= 1'b0;
				lsr_q[LS_FE] <= 1'b0;
			end
			lsr_q[LS_TFE] <= (tf_count_i == '0);
			lsr_q[LS_TE]  <= (tf_count_i == '0) && !tx_busy_i;
		end

	// bit 0 high means pending
	always_ff @(posedge clk or posedge wb_rst_i)
		if (wb_rst_i)
			iir_q <= IIR_RST;
		else if (rls)
			iir_q <= {4'b1100, II_RLS, 1'b1};
		else if (rda)
			iir_q <= {4'b1100, II_RDA, 1'b1};
		else if (thre)
			iir_q <= {4'b1100, II_THRE, 1'b1};
		else
			iir_q <= IIR_RST;

endmodule

`default_nettype wire

// File: verilog/uart_top.sv
// =====================================================================
// uart top level
// register file, baud generator, tx and rx fifos, transmitter and
// receiver
// =====================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_top (
	input  wire logic                        clk,
	input  wire logic                        wb_rst_i,
	input  wire logic [uart_pkg::ADDR_W-1:0] wb_addr_i,
	input  wire logic [7:0]                  wb_dat_i,
	input  wire logic                        wb_we_i,
	input  wire logic                        wb_stb_i,
	output logic      [7:0]                  wb_dat_o,
	input  wire logic                        srx_i,
	output logic                             stx_o,
	output logic                             int_o
);
	import uart_pkg::*;

	lcr_t             lcr;
	logic [DIV_W-1:0] div;
	logic             tick;
	logic             tf_push;
	logic             tf_pop;
	logic [7:0]       tf_data;
	logic [CNT_W-1:0] tf_count;
	logic             tx_busy;
	logic             rf_push;
	logic             rf_pop;
	logic             rf_clr_overrun;
	rx_char_t         rf_char;
	rx_char_t         rf_head;
	logic [CNT_W-1:0] rf_count;
	logic             rf_overrun;

	uart_regs i_regs (
		.clk              (clk),
		.wb_rst_i         (wb_rst_i),
		.wb_addr_i        (wb_addr_i),
		.wb_dat_i         (wb_dat_i),
		.wb_we_i          (wb_we_i),
		.wb_stb_i         (wb_stb_i),
		.wb_dat_o         (wb_dat_o),
		.lcr_o            (lcr),
		.div_o            (div),
		.tf_push_o        (tf_push),
		.rf_pop_o         (rf_pop),
		.rf_clr_overrun_o (rf_clr_overrun),
		.rf_head_i        (rf_head),
		.rf_count_i       (rf_count),
		.rf_overrun_i     (rf_overrun),
		.tf_count_i       (tf_count),
		.tx_busy_i        (tx_busy),
		.int_o            (int_o)
	);

	uart_baud_gen i_baud_gen (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.div_i    (div),
		.tick_o   (tick)
	);

	uart_fifo #(.WIDTH(8)) tx_fifo (
		.clk           (clk),
		.wb_rst_i      (wb_rst_i),
		.push_i        (tf_push),
		.pop_i         (tf_pop),
		.clr_overrun_i (1'b0),         // tx overrun not reported
		.data_i        (wb_dat_i),
		.data_o        (tf_data),
		.count_o       (tf_count),
		.overrun_o     ()
	);

	uart_fifo #(.WIDTH(10)) rx_fifo (
		.clk           (clk),
		.wb_rst_i      (wb_rst_i),
		.push_i        (rf_push),
		.pop_i         (rf_pop),
		.clr_overrun_i (rf_clr_overrun),
		.data_i        (rf_char),
		.data_o        (rf_head),
		.count_o       (rf_count),
		.overrun_o     (rf_overrun)
	);

	uart_tx i_tx (
		.clk          (clk),
		.wb_rst_i     (wb_rst_i),
		.tick_i       (tick),
		.lcr_i        (lcr),
		.fifo_data_i  (tf_data),
		.fifo_empty_i (tf_count == '0),
		.pop_o        (tf_pop),
		.stx_o        (stx_o),
		.busy_o       (tx_busy)
	);

	uart_rx i_rx (
		.clk      (clk),
		.wb_rst_i (wb_rst_i),
		.tick_i   (tick),
		.lcr_i    (lcr),
		.srx_i    (srx_i),
		.push_o   (rf_push),
		.char_o   (rf_char)
	);

endmodule

`default_nettype wire

// File: verif/uart_checker.sv
// =====================================================================
// uart protocol checker
// bound to the uart top level, watches the idle line, fifo pops and
// the interrupt output against the enabled sources
// =====================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_checker (
	input  wire logic                       clk,
	input  wire logic                       wb_rst_i,
	input  wire logic                       tick_i,
	input  wire logic                       stx_i,
	input  wire logic                       int_i,
	input  wire logic                       tf_pop_i,
	input  wire logic [uart_pkg::CNT_W-1:0] tf_count_i,
	input  wire logic                       rf_pop_i,
	input  wire logic [uart_pkg::CNT_W-1:0] rf_count_i,
	input  wire logic [2:0]                 ier_i,
	input  wire logic [1:0]                 tl_i,
	input  wire logic [7:0]                 lsr_i
);
	import uart_pkg::*;

	int               fail_cnt = 0;   // failed assertions so far
	logic             ticked;         // any baud tick since reset
	logic [CNT_W-1:0] trig;
	logic             pending;

	always_ff @(posedge clk or posedge wb_rst_i)
		if (wb_rst_i)
			ticked <= 1'b0;
		else if (tick_i)
			ticked <= 1'b1;

	always_comb
		case (tl_i)
			2'b00:   trig = CNT_W'(1);
			2'b01:   trig = CNT_W'(4);
			2'b10:   trig = CNT_W'(8);
			default: trig = CNT_W'(14);
		endcase

	// rls, rda, thre, each behind its ier enable
	assign pending = (ier_i[IE_RLS] && (lsr_i[LS_OE] || lsr_i[LS_PE] || lsr_i[LS_FE]))
		|| (ier_i[IE_RDA] && (rf_count_i >= trig))
		|| (ier_i[IE_THRE] && lsr_i[LS_TFE]);

	idle_line: assert property (@(posedge clk) disable iff (wb_rst_i) !ticked |-> stx_i)
		else
		begin
			fail_cnt++;
			$error("stx_o left the idle level before any baud tick");
		end

	tx_pop: assert property (@(posedge clk) disable iff (wb_rst_i)
		tf_pop_i |-> (tf_count_i != '0))
		else
		begin
			fail_cnt++;
			$error("pop from an empty tx fifo");
		end

	rx_pop: assert property (@(posedge clk) disable iff (wb_rst_i)
		rf_pop_i |-> (rf_count_i != '0))
		else
		begin
			fail_cnt++;
			$error("pop from an empty rx fifo");
		end

	// iir is registered, so int_o follows the sources by one clock
	int_out: assert property (@(posedge clk) disable iff (wb_rst_i) int_i == $past(pending))
		else
		begin
			fail_cnt++;
			$error("int_o differs from the enabled pending sources");
		end

endmodule

bind uart_top uart_checker i_checker (
	.clk        (clk),
	.wb_rst_i   (wb_rst_i),
	.tick_i     (tick),
	.stx_i      (stx_o),
	.int_i      (int_o),
	.tf_pop_i   (tf_pop),
	.tf_count_i (tf_count),
	.rf_pop_i   (rf_pop),
	.rf_count_i (rf_count),
	.ier_i      (i_regs.ier_q),
	.tl_i       (i_regs.tl_q),
	.lsr_i      (i_regs.lsr_q)
);

`default_nettype wire

// File: verif/uart_tb.sv
// =====================================================================
// uart testbench
// reset values, divisor latch, tx framing for every format, rx
// errors, interrupt priority and rx overrun, checked by assertions
// =====================================================================
`timescale 1ns/1ps
`default_nettype none

module uart_tb;
	import uart_pkg::*;

	localparam int BIT_CLKS    = 32;    // 16 ticks at divisor 1
	localparam int START_LIMIT = 5;     // 2 ticks from thr write, plus the edge that sees it
	localparam int POLL_LIMIT  = 200;   // lsr reads before giving up
	localparam int RX_BITS     = 8;     // rx frames are 8 bits, even parity
	localparam int RX_MODE     = 2;

	logic              clk;
	logic              wb_rst;
	logic [ADDR_W-1:0] wb_addr;
	logic [7:0]        wb_dat;
	logic              wb_we;
	logic              wb_stb;
	logic [7:0]        rd_data;
	logic              srx;
	logic              stx;
	logic              irq;

	logic              chk_valid;      // one-cycle compare strobe
	logic [7:0]        chk_exp;
	logic [7:0]        chk_act;
	string             chk_name;
	logic [7:0]        sent_q[$];      // bytes driven on srx, oldest first

	uart_top i_uart_top (
		.clk       (clk),
		.wb_rst_i  (wb_rst),
		.wb_addr_i (wb_addr),
		.wb_dat_i  (wb_dat),
		.wb_we_i   (wb_we),
		.wb_stb_i  (wb_stb),
		.wb_dat_o  (rd_data),
		.srx_i     (srx),
		.stx_o     (stx),
		.int_o     (irq)
	);

	value_check: assert property (@(posedge clk) chk_valid |-> chk_act == chk_exp)
		else
		begin
			$display("Mismatch in %s: expected %02h, actual %02h", chk_name, chk_exp, chk_act);
			$display("Test FAILED");
			$fatal(1, "stopped at the first mismatch");
		end

	always @(i_uart_top.i_checker.fail_cnt)
		if (i_uart_top.i_checker.fail_cnt != 0)
		begin
			$display("A checker assertion failed, see the error above");
			$display("Test FAILED");
			$fatal(1, "stopped at a checker assertion");
		end

	initial
	begin
		clk = 1'b0;
		forever
			#10 clk = ~clk;                 // 20 ns period
	end

	// odd, even, stick 1, stick 0 as the line standard defines them
	function automatic logic expected_parity(input logic [7:0] data, input int nbits,
			input int pmode);
		logic ones;
		int   i;
		ones = 1'b0;
		for (i = 0; i < nbits; i++)
			ones = ones ^ data[i];
		case (pmode)
			1:       expected_parity = ~ones;  // total count of ones odd
			2:       expected_parity = ones;
			3:       expected_parity = 1'b1;
			default: expected_parity = 1'b0;
		endcase
	endfunction

	// pmode 0 none, 1 odd, 2 even, 3 stick 1, 4 stick 0
	function automatic logic [7:0] lcr_value(input int nbits, input int pmode);
		logic pen;
		logic even;
		logic stick;
		pen   = (pmode != 0);
		even  = (pmode == 2) || (pmode == 4);
		stick = (pmode >= 3);
		lcr_value = {2'b00, stick, even, pen, 1'b0, 2'(nbits - 5)};
	endfunction

	function automatic logic [7:0] data_mask(input int nbits);
		data_mask = 8'((9'h1 << nbits) - 1);
	endfunction

	task automatic fail_timeout(input string what);
		$display("Timed out waiting for %s", what);
		$display("Test FAILED");
		$fatal(1, "stopped on a timeout");
	endtask

	// held over two edges so the action block sees stable values
	task automatic check_value(input string name, input logic [7:0] exp, input logic [7:0] act);
		chk_name  <= name;
		chk_exp   <= exp;
		chk_act   <= act;
		chk_valid <= 1'b1;
		@(posedge clk);
		chk_valid <= 1'b0;
		@(posedge clk);
	endtask

	task automatic bus_write(input logic [ADDR_W-1:0] addr, input logic [7:0] data);
		wb_addr <= addr;
		wb_dat  <= data;
		wb_we   <= 1'b1;
		wb_stb  <= 1'b1;
		@(posedge clk);
		wb_stb  <= 1'b0;
		wb_we   <= 1'b0;
	endtask

	task automatic bus_read(input logic [ADDR_W-1:0] addr, output logic [7:0] data);
		wb_addr <= addr;
		wb_we   <= 1'b0;
		wb_stb  <= 1'b1;
		@(posedge clk);
		wb_stb  <= 1'b0;
		@(posedge clk);
		data = rd_data;                     // held since the read edge
	endtask

	task automatic read_check(input string name, input logic [ADDR_W-1:0] addr,
			input logic [7:0] mask, input logic [7:0] exp);
		logic [7:0] v;
		bus_read(addr, v);
		check_value(name, exp, v & mask);
	endtask

	task automatic receive_check(input string name);
		logic [7:0] v;
		bus_read(REG_RB, v);
		check_value(name, sent_q.pop_front(), v);
	endtask

	task automatic wait_lsr(input logic [7:0] mask, input string what);
		logic [7:0] v;
		int         n;
		n = 0;
		v = 8'h00;
		while ((v & mask) != mask && n < POLL_LIMIT)
		begin
			bus_read(REG_LS, v);
			n++;
		end
		if ((v & mask) != mask)
			fail_timeout(what);
	endtask

	// one 8E frame on srx, optionally with bad parity or a 0 stop bit
	task automatic send_frame(input logic [7:0] data, input logic flip_par,
			input logic stop_bit);
		int i;
		sent_q.push_back(data);
		srx <= 1'b0;                        // start bit
		repeat (BIT_CLKS) @(posedge clk);
		for (i = 0; i < RX_BITS; i++)
		begin
			srx <= data[i];                 // lsb first
			repeat (BIT_CLKS) @(posedge clk);
		end
		srx <= expected_parity(data, RX_BITS, RX_MODE) ^ flip_par;
		repeat (BIT_CLKS) @(posedge clk);
		srx <= stop_bit;
		repeat (BIT_CLKS) @(posedge clk);
		srx <= 1'b1;                        // idle gap
		repeat (2 * BIT_CLKS) @(posedge clk);
	endtask

	// serial monitor, samples stx mid-bit from the start edge
	task automatic capture_frame(input int nbits, input logic has_par, output logic start,
			output logic [7:0] data, output logic par, output logic stop);
		int n;
		int i;
		n = 0;
		while (stx !== 1'b0 && n < START_LIMIT)
		begin
			@(posedge clk);
			n++;
		end
		if (stx !== 1'b0)
			fail_timeout("the start bit on stx_o");
		repeat (BIT_CLKS / 2) @(posedge clk);
		start = stx;
		data  = 8'h00;
		par   = 1'b0;
		for (i = 0; i < nbits; i++)
		begin
			repeat (BIT_CLKS) @(posedge clk);
			data[i] = stx;
		end
		if (has_par)
		begin
			repeat (BIT_CLKS) @(posedge clk);
			par = stx;
		end
		repeat (BIT_CLKS) @(posedge clk);
		stop = stx;
	endtask

	initial
	begin
		logic [7:0] d;
		logic [7:0] cap;
		logic       st;
		logic       par;
		logic       stp;
		string      tname;
		int         nb;
		int         pm;
		int         k;

		void'($urandom(6379));
		wb_rst    <= 1'b1;
		wb_addr   <= '0;
		wb_dat    <= 8'h00;
		wb_we     <= 1'b0;
		wb_stb    <= 1'b0;
		srx       <= 1'b1;                  // line idles high
		chk_valid <= 1'b0;
		repeat (8) @(posedge clk);
		wb_rst <= 1'b0;
		@(posedge clk);

		read_check("reset lcr", REG_LC, 8'hFF, 8'h03);
		read_check("reset ier", REG_IE, 8'hFF, 8'h00);
		read_check("reset iir", REG_II, 8'hFF, 8'hC0);
		read_check("reset lsr", REG_LS, 8'hFF, 8'h60);
		check_value("reset stx", 8'h01, {7'b0, stx});

		bus_write(REG_LC, 8'h80);           // dlab on
		bus_write(REG_RB, 8'h34);
		bus_write(REG_IE, 8'h12);
		read_check("dll readback", REG_RB, 8'hFF, 8'h34);
		read_check("dlm readback", REG_IE, 8'hFF, 8'h12);
		bus_write(REG_RB, 8'h01);           // divisor 1, 32 clocks per bit
		bus_write(REG_IE, 8'h00);
		read_check("dll final", REG_RB, 8'hFF, 8'h01);
		bus_write(REG_LC, 8'h03);
		read_check("ier untouched by dlm", REG_IE, 8'hFF, 8'h00);
		bus_write(REG_IE, 8'h05);
		read_check("ier after dlab", REG_IE, 8'hFF, 8'h05);
		bus_write(REG_IE, 8'h00);

		for (nb = 5; nb <= 8; nb++)
			for (pm = 0; pm < 5; pm++)
			begin
				d     = 8'($urandom);
				tname = $sformatf("tx %0d bits mode %0d", nb, pm);
				bus_write(REG_LC, lcr_value(nb, pm));
				bus_write(REG_RB, d);
				capture_frame(nb, pm != 0, st, cap, par, stp);
				check_value({tname, " start"}, 8'h00, {7'b0, st});
				check_value({tname, " data"}, d & data_mask(nb), cap);
				if (pm != 0)
					check_value({tname, " parity"}, {7'b0, expected_parity(d, nb, pm)},
						{7'b0, par});
				check_value({tname, " stop"}, 8'h01, {7'b0, stp});
				wait_lsr(8'h60, "the transmitter to empty");
				read_check({tname, " lsr"}, REG_LS, 8'h60, 8'h60);
			end

		bus_write(REG_LC, lcr_value(RX_BITS, RX_MODE));
		send_frame(8'($urandom), 1'b0, 1'b1);
		wait_lsr(8'h01, "received data");
		receive_check("rx good data");
		send_frame(8'($urandom), 1'b1, 1'b1);
		wait_lsr(8'h01, "received data");
		receive_check("rx parity data");
		read_check("rx parity lsr", REG_LS, 8'h0F, 8'h04);
		read_check("rx parity cleared", REG_LS, 8'h0F, 8'h00);
		send_frame(8'($urandom), 1'b0, 1'b0);
		wait_lsr(8'h01, "received data");
		receive_check("rx framing data");
		read_check("rx framing lsr", REG_LS, 8'h0F, 8'h08);
		read_check("rx framing cleared", REG_LS, 8'h0F, 8'h00);

		bus_write(REG_II, 8'h40);           // trigger level 4
		bus_write(REG_IE, 8'h01);           // rda only
		for (k = 0; k < 3; k++)
		begin
			send_frame(8'($urandom), 1'b0, 1'b1);
			read_check("rda below trigger", REG_II, 8'hFF, 8'hC0);
		end
		send_frame(8'($urandom), 1'b0, 1'b1);
		read_check("rda at trigger", REG_II, 8'hFF, {4'hC, II_RDA, 1'b1});
		check_value("rda int_o", 8'h01, {7'b0, irq});
		bus_write(REG_IE, 8'h05);           // rls and rda
		send_frame(8'($urandom), 1'b1, 1'b1);
		send_frame(8'($urandom), 1'b0, 1'b1);
		for (k = 0; k < 5; k++)
			receive_check("rda drain");
		bus_write(REG_II, 8'h00);           // trigger level 1, rda pending too
		read_check("rls over rda", REG_II, 8'hFF, {4'hC, II_RLS, 1'b1});
		read_check("rls lsr", REG_LS, 8'h0F, 8'h05);
		read_check("rda after rls", REG_II, 8'hFF, {4'hC, II_RDA, 1'b1});
		receive_check("rda last data");
		read_check("nothing pending", REG_II, 8'hFF, 8'hC0);
		bus_write(REG_IE, 8'h02);           // thre only
		@(posedge clk);                     // iir follows ier one clock later
		read_check("thre pending", REG_II, 8'hFF, {4'hC, II_THRE, 1'b1});
		check_value("thre int_o", 8'h01, {7'b0, irq});
		bus_write(REG_IE, 8'h00);
		@(posedge clk);
		read_check("all masked", REG_II, 8'hFF, 8'hC0);

		for (k = 0; k < 17; k++)
			send_frame(8'($urandom), 1'b0, 1'b1);
		sent_q.delete(16);                  // the seventeenth byte is lost
		read_check("overrun lsr", REG_LS, 8'h03, 8'h03);
		read_check("overrun cleared", REG_LS, 8'h03, 8'h01);
		for (k = 0; k < 16; k++)
			receive_check("overrun drain");
		read_check("rx fifo empty", REG_LS, 8'h01, 8'h00);

		if (i_uart_top.i_checker.fail_cnt == 0)
		begin
			$display("Test OK");
		end
		else
		begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: compile.f
verilog/uart_pkg.sv
verilog/uart_baud_gen.sv
verilog/uart_fifo.sv
verilog/uart_tx.sv
verilog/uart_rx.sv
verilog/uart_regs.sv
verilog/uart_top.sv
verif/uart_checker.sv
verif/uart_tb.sv

// File: Bender.yml
package:
  name: uart

sources:
  - verilog/uart_pkg.sv
  - verilog/uart_baud_gen.sv
  - verilog/uart_fifo.sv
  - verilog/uart_tx.sv
  - verilog/uart_rx.sv
  - verilog/uart_regs.sv
  - verilog/uart_top.sv
  - target: simulation
    files:
      - verif/uart_checker.sv
      - verif/uart_tb.sv
